// ==== rv_writeback.f ====
+incdir+verif
rtl/wb_pkg.sv
rtl/wb_select.sv
rtl/gpr_file.sv
rtl/store_unit.sv
rtl/wb_top.sv
verif/wb_tb.sv

// ==== verif/wb_vectors.svh ====
`ifndef WB_VECTORS_SVH
`define WB_VECTORS_SVH

// sign bits set in the low lanes of one source and clear in the other
localparam logic [63:0] EX_VAL  = 64'h0123_4567_89ab_cdef;
localparam logic [63:0] MEM_VAL = 64'hfedc_ba98_7654_3210;
localparam logic [63:0] SRC_VAL = 64'h1122_3344_5566_7788;  // store data in x16

task automatic build_table();
    // registers out of reset
    reg_check(0, 64'h0);
    reg_check(1, 64'h0);
    reg_check(17, 64'h0);
    reg_check(31, 64'h0);

    // every extension code, both sources, back to back
    write_op(1, 1'b0, EX_VAL, MEM_VAL, EXT_DWORD, 1'b0, 1'b1);
    write_op(2, 1'b1, EX_VAL, MEM_VAL, EXT_DWORD, 1'b0, 1'b1);
    write_op(3, 1'b0, EX_VAL, MEM_VAL, EXT_SWORD, 1'b0, 1'b1);
    write_op(4, 1'b1, EX_VAL, MEM_VAL, EXT_SWORD, 1'b0, 1'b1);
    write_op(5, 1'b0, EX_VAL, MEM_VAL, EXT_ZWORD, 1'b0, 1'b1);
    write_op(13, 1'b1, EX_VAL, MEM_VAL, EXT_ZWORD, 1'b0, 1'b1);
    write_op(6, 1'b0, EX_VAL, MEM_VAL, EXT_SHALF, 1'b0, 1'b1);
    write_op(7, 1'b1, EX_VAL, MEM_VAL, EXT_SHALF, 1'b0, 1'b1);
    write_op(8, 1'b0, EX_VAL, MEM_VAL, EXT_ZHALF, 1'b0, 1'b1);
    write_op(14, 1'b1, EX_VAL, MEM_VAL, EXT_ZHALF, 1'b0, 1'b1);
    write_op(9, 1'b0, EX_VAL, MEM_VAL, EXT_SBYTE, 1'b0, 1'b1);
    write_op(10, 1'b1, EX_VAL, MEM_VAL, EXT_SBYTE, 1'b0, 1'b1);
    write_op(11, 1'b0, EX_VAL, MEM_VAL, EXT_ZBYTE, 1'b0, 1'b1);
    write_op(12, 1'b1, EX_VAL, MEM_VAL, EXT_ZBYTE, 1'b0, 1'b1);
    write_op(0, 1'b0, EX_VAL, MEM_VAL, EXT_DWORD, 1'b0, 1'b1);  // retires, x0 unchanged
    reg_check(1, 64'h0123_4567_89ab_cdef);
    reg_check(2, 64'hfedc_ba98_7654_3210);
    reg_check(3, 64'hffff_ffff_89ab_cdef);
    reg_check(4, 64'h0000_0000_7654_3210);
    reg_check(5, 64'h0000_0000_89ab_cdef);
    reg_check(13, 64'h0000_0000_7654_3210);
    reg_check(6, 64'hffff_ffff_ffff_cdef);
    reg_check(7, 64'h0000_0000_0000_3210);
    reg_check(8, 64'h0000_0000_0000_cdef);
    reg_check(14, 64'h0000_0000_0000_3210);
    reg_check(9, 64'hffff_ffff_ffff_ffef);
    reg_check(10, 64'h0000_0000_0000_0010);
    reg_check(11, 64'h0000_0000_0000_00ef);
    reg_check(12, 64'h0000_0000_0000_0010);
    reg_check(0, 64'h0);

    rand_write(20, 1'b0, EXT_SWORD);
    drawn_check(20);
    rand_write(21, 1'b1, EXT_ZHALF);
    drawn_check(21);
    rand_write(22, 1'b0, EXT_SBYTE);
    drawn_check(22);
    rand_write(23, 1'b1, EXT_DWORD);
    drawn_check(23);

    // store operands: x15 and x18 as bases, x16 as data
    write_op(15, 1'b0, 64'h1_0000, MEM_VAL, EXT_DWORD, 1'b0, 1'b1);
    write_op(16, 1'b1, EX_VAL, SRC_VAL, EXT_DWORD, 1'b0, 1'b1);
    write_op(18, 1'b0, 64'h2_0008, MEM_VAL, EXT_DWORD, 1'b0, 1'b1);

    // each aligned lane, negative offsets from x18
    store_op(15, 16, 12'h000, ST_BYTE, 64'h1_0000, 64'h0000_0000_0000_0088, 8'h01);
    store_op(15, 16, 12'h001, ST_BYTE, 64'h1_0001, 64'h0000_0000_0000_8800, 8'h02);
    store_op(15, 16, 12'h002, ST_BYTE, 64'h1_0002, 64'h0000_0000_0088_0000, 8'h04);
    store_op(15, 16, 12'h003, ST_BYTE, 64'h1_0003, 64'h0000_0000_8800_0000, 8'h08);
    store_op(15, 16, 12'h004, ST_BYTE, 64'h1_0004, 64'h0000_0088_0000_0000, 8'h10);
    store_op(15, 16, 12'h005, ST_BYTE, 64'h1_0005, 64'h0000_8800_0000_0000, 8'h20);
    store_op(15, 16, 12'h006, ST_BYTE, 64'h1_0006, 64'h0088_0000_0000_0000, 8'h40);
    store_op(18, 16, 12'hfff, ST_BYTE, 64'h2_0007, 64'h8800_0000_0000_0000, 8'h80);
    store_op(15, 16, 12'h000, ST_HALF, 64'h1_0000, 64'h0000_0000_0000_7788, 8'h03);
    store_op(15, 16, 12'h002, ST_HALF, 64'h1_0002, 64'h0000_0000_7788_0000, 8'h0c);
    store_op(18, 16, 12'hffc, ST_HALF, 64'h2_0004, 64'h0000_7788_0000_0000, 8'h30);
    store_op(15, 16, 12'h006, ST_HALF, 64'h1_0006, 64'h7788_0000_0000_0000, 8'hc0);
    store_op(18, 16, 12'hff8, ST_WORD, 64'h2_0000, 64'h0000_0000_5566_7788, 8'h0f);
    store_op(15, 16, 12'h004, ST_WORD, 64'h1_0004, 64'h5566_7788_0000_0000, 8'hf0);
    store_op(15, 16, 12'h008, ST_DWORD, 64'h1_0008, SRC_VAL, 8'hff);
    store_op(18, 16, 12'h800, ST_DWORD, 64'h1_f808, SRC_VAL, 8'hff);

    misaligned_store(15, 16, 12'h001, ST_HALF);
    misaligned_store(15, 16, 12'h002, ST_WORD);
    misaligned_store(15, 16, 12'h004, ST_DWORD);
    misaligned_store(18, 16, 12'hfff, ST_WORD);
    store_op(15, 16, 12'h000, ST_BYTE, 64'h1_0000, 64'h0000_0000_0000_0088, 8'h01);

    // x0 as base and as data
    store_op(0, 16, 12'h010, ST_DWORD, 64'h10, SRC_VAL, 8'hff);
    store_op(15, 0, 12'h004, ST_WORD, 64'h1_0004, 64'h0, 8'hf0);
    idle_cycle();

    // ebreak still writes and retires, everything after is dropped
    write_op(19, 1'b0, 64'hdead_beef_0000_1234, MEM_VAL, EXT_DWORD, 1'b1, 1'b1);
    reg_check(19, 64'hdead_beef_0000_1234);
    write_op(19, 1'b0, 64'h5555_5555_5555_5555, MEM_VAL, EXT_DWORD, 1'b0, 1'b0);
    write_op(1, 1'b0, 64'h0, MEM_VAL, EXT_DWORD, 1'b0, 1'b0);
    write_op(25, 1'b0, EX_VAL, MEM_VAL, EXT_DWORD, 1'b1, 1'b0);
    blocked_store(15, 16, 12'h000, ST_BYTE);
    blocked_store(15, 16, 12'h001, ST_HALF);
    reg_check(19, 64'hdead_beef_0000_1234);
    reg_check(1, 64'h0123_4567_89ab_cdef);
    reg_check(25, 64'h0);
    idle_cycle();
endtask

`endif

// ==== verif/wb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_tb
    import wb_pkg::*;
();

    typedef enum logic [1:0] {
        K_IDLE  = 2'd0,
        K_WRITE = 2'd1,
        K_STORE = 2'd2,
        K_CHECK = 2'd3
    } kind_e;

    // one table row, one clock cycle
    typedef struct packed {
        kind_e       kind;
        logic [4:0]  rd;        // write destination or register to peek
        logic        from_mem;
        logic [63:0] ex_val;
        logic [63:0] mem_val;
        ext_mode_e   ext;
        logic [63:0] pc;
        logic        brk;       // ebreak
        logic        rnd;       // sources drawn from $random
        logic        exp_ret;
        logic [4:0]  base;
        logic [4:0]  src;
        logic [11:0] imm;
        st_size_e    size;
        logic        exp_st;
        logic        exp_mis;
        logic [63:0] exp_addr;
        logic [63:0] exp_data;
        logic [7:0]  exp_mask;
        logic [63:0] exp_val;   // dbg_data for check rows
        logic        use_rand;
    } vec_t;

    logic        clk;
    logic        rst_n;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic        wb_from_mem;
    logic [63:0] ex_result;
    logic [63:0] mem_result;
    ext_mode_e   ext_mode;
    logic [63:0] wb_pc;
    logic        ebreak;
    logic        st_valid;
    logic [4:0]  st_base_reg;
    logic [4:0]  st_src_reg;
    logic [11:0] st_imm;
    st_size_e    st_size;
    logic [4:0]  dbg_addr;
    logic [63:0] dbg_data;
    logic        mem_wr_valid;
    logic [63:0] mem_wr_addr;
    logic [63:0] mem_wr_data;
    logic [7:0]  mem_wr_mask;
    logic        mem_wr_misaligned;
    logic        retire_valid;
    logic [63:0] retire_pc;
    logic        halted;

    vec_t        vecs[$];
    vec_t        prev;
    vec_t        row;
    integer      seed;
    int          n_checks = 0;
    int          n_errors = 0;
    int          row_idx = -1;
    int          limit;
    logic        table_built = 1'b0;
    logic        exp_halted = 1'b0;
    logic [63:0] rand_exp = '0;            // expected value of the last random write
    logic [63:0] next_pc = 64'h8000_0000;

    wb_top UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .wb_valid         (wb_valid),
        .wb_rd            (wb_rd),
        .wb_from_mem      (wb_from_mem),
        .ex_result        (ex_result),
        .mem_result       (mem_result),
        .ext_mode         (ext_mode),
        .wb_pc            (wb_pc),
        .ebreak           (ebreak),
        .st_valid         (st_valid),
        .st_base_reg      (st_base_reg),
        .st_src_reg       (st_src_reg),
        .st_imm           (st_imm),
        .st_size          (st_size),
        .dbg_addr         (dbg_addr),
        .dbg_data         (dbg_data),
        .mem_wr_valid     (mem_wr_valid),
        .mem_wr_addr      (mem_wr_addr),
        .mem_wr_data      (mem_wr_data),
        .mem_wr_mask      (mem_wr_mask),
        .mem_wr_misaligned(mem_wr_misaligned),
        .retire_valid     (retire_valid),
        .retire_pc        (retire_pc),
        .halted           (halted)
    );

    // row builders used by the table
    function automatic void write_op(logic [4:0] rd, logic from_mem, logic [63:0] ex_val,
                                     logic [63:0] mem_val, ext_mode_e ext, logic brk,
                                     logic exp_ret);
        vec_t r;
        r = '0;
        r.kind = K_WRITE;
        r.rd = rd;
        r.from_mem = from_mem;
        r.ex_val = ex_val;
        r.mem_val = mem_val;
        r.ext = ext;
        r.brk = brk;
        r.exp_ret = exp_ret;
        r.pc = next_pc;
        next_pc += 64'd4;
        vecs.push_back(r);
    endfunction

    function automatic void rand_write(logic [4:0] rd, logic from_mem, ext_mode_e ext);
        write_op(rd, from_mem, '0, '0, ext, 1'b0, 1'b1);
        vecs[vecs.size()-1].rnd = 1'b1;
    endfunction

    function automatic void reg_check(logic [4:0] rd, logic [63:0] val);
        vec_t r;
        r = '0;
        r.kind = K_CHECK;
        r.rd = rd;
        r.exp_val = val;
        vecs.push_back(r);
    endfunction

    function automatic void drawn_check(logic [4:0] rd);
        reg_check(rd, '0);
        vecs[vecs.size()-1].use_rand = 1'b1;
    endfunction

    function automatic void store_op(logic [4:0] base, logic [4:0] src, logic [11:0] imm,
                                     st_size_e size, logic [63:0] addr, logic [63:0] data,
                                     logic [7:0] mask);
        vec_t r;
        r = '0;
        r.kind = K_STORE;
        r.base = base;
        r.src = src;
        r.imm = imm;
        r.size = size;
        r.exp_st = 1'b1;
        r.exp_addr = addr;
        r.exp_data = data;
        r.exp_mask = mask;
        vecs.push_back(r);
    endfunction

    function automatic void misaligned_store(logic [4:0] base, logic [4:0] src,
                                             logic [11:0] imm, st_size_e size);
        store_op(base, src, imm, size, '0, '0, '0);
        vecs[vecs.size()-1].exp_st = 1'b0;
        vecs[vecs.size()-1].exp_mis = 1'b1;
    endfunction

    function automatic void blocked_store(logic [4:0] base, logic [4:0] src,
                                          logic [11:0] imm, st_size_e size);
        store_op(base, src, imm, size, '0, '0, '0);
        vecs[vecs.size()-1].exp_st = 1'b0;  // no strobe at all once halted
    endfunction

    function automatic void idle_cycle();
        vec_t r;
        r = '0;
        vecs.push_back(r);
    endfunction

    `include "wb_vectors.svh"

    // reference extension: keep the low n bits, fill above with zero or the sign bit
    function automatic logic [63:0] extend_ref(logic [63:0] v, ext_mode_e mode);
        int          nbits;
        logic        signed_mode;
        logic [63:0] keep;
        signed_mode = (mode == EXT_SWORD) || (mode == EXT_SHALF) || (mode == EXT_SBYTE);
        case (mode)
            EXT_SWORD, EXT_ZWORD: nbits = 32;
            EXT_SHALF, EXT_ZHALF: nbits = 16;
            EXT_SBYTE, EXT_ZBYTE: nbits = 8;
            default:              nbits = 64;
        endcase
        if (nbits == 64) begin
            return v;
        end
        keep = (64'd1 << nbits) - 64'd1;
        if (signed_mode && v[nbits-1]) begin
            return v | ~keep;
        end
        return v & keep;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("error: row %0d %s = %0h, expected %0h", row_idx, name, got, exp);
        end
    endtask

    task automatic drive_row(input vec_t r);
        logic [63:0] ex_val;
        logic [63:0] mem_val;
        ex_val = r.ex_val;
        mem_val = r.mem_val;
        wb_valid = 1'b0;
        st_valid = 1'b0;
        ebreak = 1'b0;
        if (r.rnd) begin
            ex_val = {$random(seed), $random(seed)};
            mem_val = {$random(seed), $random(seed)};
            rand_exp = extend_ref(r.from_mem ? mem_val : ex_val, r.ext);
        end
        case (r.kind)
            K_WRITE: begin
                wb_valid = 1'b1;
                wb_rd = r.rd;
                wb_from_mem = r.from_mem;
                ex_result = ex_val;
                mem_result = mem_val;
                ext_mode = r.ext;
                wb_pc = r.pc;
                ebreak = r.brk;
            end
            K_STORE: begin
                st_valid = 1'b1;
                st_base_reg = r.base;
                st_src_reg = r.src;
                st_imm = r.imm;
                st_size = r.size;
            end
            K_CHECK: dbg_addr = r.rd;
            default: ;
        endcase
    endtask

    // outputs in the cycle after row p was driven
    task automatic check_outputs(input vec_t p);
        logic exp_ret;
        logic exp_st;
        logic exp_mis;
        exp_ret = (p.kind == K_WRITE) && p.exp_ret;
        exp_st = (p.kind == K_STORE) && p.exp_st;
        exp_mis = (p.kind == K_STORE) && p.exp_mis;
        compare("retire_valid", retire_valid, exp_ret);
        if (exp_ret) begin
            compare("retire_pc", retire_pc, p.pc);
        end
        compare("mem_wr_valid", mem_wr_valid, exp_st);
        compare("mem_wr_misaligned", mem_wr_misaligned, exp_mis);
        if (exp_st) begin
            compare("mem_wr_addr", mem_wr_addr, p.exp_addr);
            compare("mem_wr_data", mem_wr_data, p.exp_data);
            compare("mem_wr_mask", mem_wr_mask, p.exp_mask);
        end
        compare("halted", halted, exp_halted);
        if (p.kind == K_CHECK) begin
            compare("dbg_data", dbg_data, p.use_rand ? rand_exp : p.exp_val);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        wait (table_built);
        limit = vecs.size() + 20;
        #(limit * 10);
        $display("timeout: run still going after %0d clock cycles", limit);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        seed = 32'he296a7c6;
        rst_n = 1'b0;
        wb_valid = 1'b0;
        wb_rd = '0;
        wb_from_mem = 1'b0;
        ex_result = '0;
        mem_result = '0;
        ext_mode = EXT_DWORD;
        wb_pc = '0;
        ebreak = 1'b0;
        st_valid = 1'b0;
        st_base_reg = '0;
        st_src_reg = '0;
        st_imm = '0;
        st_size = ST_BYTE;
        dbg_addr = '0;
        build_table();
        table_built = 1'b1;

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        prev = '0;
        check_outputs(prev);  // strobes and halted low out of reset

        for (int i = 0; i < vecs.size(); i++) begin
            @(posedge clk);
            #1;
            check_outputs(prev);
            row_idx = i;
            row = vecs[i];
            drive_row(row);
            if (row.kind == K_WRITE && row.brk) begin
                exp_halted = 1'b1;  // sticky
            end
            prev = row;
        end
        @(posedge clk);
        #1;
        check_outputs(prev);

        $display("checks run %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/wb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_top
    import wb_pkg::*;
#(
    parameter int REG_ADDR_W = 5  // 4 for the 16-register variant
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // writeback
    input  logic                  wb_valid,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic                  wb_from_mem,
    input  logic [XLEN-1:0]       ex_result,
    input  logic [XLEN-1:0]       mem_result,
    input  ext_mode_e             ext_mode,
    input  logic [XLEN-1:0]       wb_pc,
    input  logic                  ebreak,

    // store
    input  logic                  st_valid,
    input  logic [REG_ADDR_W-1:0] st_base_reg,
    input  logic [REG_ADDR_W-1:0] st_src_reg,
    input  logic [11:0]           st_imm,
    input  st_size_e              st_size,

    // architectural state peek
    input  logic [REG_ADDR_W-1:0] dbg_addr,
    output logic [XLEN-1:0]       dbg_data,

    output logic                  mem_wr_valid,
    output logic [XLEN-1:0]       mem_wr_addr,
    output logic [XLEN-1:0]       mem_wr_data,
    output logic [XLEN/8-1:0]     mem_wr_mask,
    output logic                  mem_wr_misaligned,

    output logic                  retire_valid,
    output logic [XLEN-1:0]       retire_pc,
    output logic                  halted
);

    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic [REG_ADDR_W-1:0] base_addr;
    logic [REG_ADDR_W-1:0] src_addr;
    logic [XLEN-1:0]       base_data;
    logic [XLEN-1:0]       src_data;

    wb_select #(
        .REG_ADDR_W(REG_ADDR_W)
    ) u_wb_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_from_mem (wb_from_mem),
        .ex_result   (ex_result),
        .mem_result  (mem_result),
        .ext_mode    (ext_mode),
        .wb_pc       (wb_pc),
        .ebreak      (ebreak),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .halted      (halted)
    );

    gpr_file #(
        .REG_ADDR_W(REG_ADDR_W)
    ) u_gpr_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata),
        .base_addr(base_addr),
        .src_addr (src_addr),
        .dbg_addr (dbg_addr),
        .base_data(base_data),
        .src_data (src_data),
        .dbg_data (dbg_data)
    );

    store_unit #(
        .REG_ADDR_W(REG_ADDR_W)
    ) u_store_unit (
        .clk              (clk),
        .rst_n            (rst_n),
        .st_valid         (st_valid),
        .st_base_reg      (st_base_reg),
        .st_src_reg       (st_src_reg),
        .st_imm           (st_imm),
        .st_size          (st_size),
        .halted           (halted),  // stores blocked after ebreak
        .base_addr        (base_addr),
        .src_addr         (src_addr),
        .base_data        (base_data),
        .src_data         (src_data),
        .mem_wr_valid     (mem_wr_valid),
        .mem_wr_addr      (mem_wr_addr),
        .mem_wr_data      (mem_wr_data),
        .mem_wr_mask      (mem_wr_mask),
        .mem_wr_misaligned(mem_wr_misaligned)
    );

endmodule

`default_nettype wire

// ==== rtl/store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_unit
    import wb_pkg::*;
#(
    parameter int REG_ADDR_W = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  st_valid,
    input  logic [REG_ADDR_W-1:0] st_base_reg,
    input  logic [REG_ADDR_W-1:0] st_src_reg,
    input  logic [11:0]           st_imm,
    input  st_size_e              st_size,
    input  logic                  halted,

    // register file reads
    output logic [REG_ADDR_W-1:0] base_addr,
    output logic [REG_ADDR_W-1:0] src_addr,
    input  logic [XLEN-1:0]       base_data,
    input  logic [XLEN-1:0]       src_data,

    output logic                  mem_wr_valid,
    output logic [XLEN-1:0]       mem_wr_addr,
    output logic [XLEN-1:0]       mem_wr_data,
    output logic [XLEN/8-1:0]     mem_wr_mask,
    output logic                  mem_wr_misaligned
);

    logic [XLEN-1:0]   addr;
    logic [2:0]        offs;       // byte lane within the doubleword
    logic              aligned;
    logic              accept;
    logic [XLEN/8-1:0] size_ones;  // mask before shifting
    lane_word_u        src_u;
    lane_word_u        place_u;

    assign base_addr = st_base_reg;
    assign src_addr  = st_src_reg;

    assign addr   = base_data + {{(XLEN-12){st_imm[11]}}, st_imm};
    assign offs   = addr[2:0];
    assign accept = st_valid && !halted;
    assign src_u  = src_data;

    always_comb begin
        place_u = '0;  // unused lanes carry zero
        case (st_size)
            ST_BYTE: begin
                aligned   = 1'b1;
                size_ones = 8'h01;
                place_u.bytes[offs] = src_u.bytes[0];
            end
            ST_HALF: begin
                aligned   = (offs[0] == 1'b0);
                size_ones = 8'h03;
                place_u.halves[offs[2:1]] = src_u.halves[0];
            end
            ST_WORD: begin
                aligned   = (offs[1:0] == 2'b00);
                size_ones = 8'h0f;
                place_u.words[offs[2]] = src_u.words[0];
            end
            default: begin  // ST_DWORD
                aligned   = (offs == 3'b000);
                size_ones = 8'hff;
                place_u.dword = src_u.dword;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wr_valid      <= 1'b0;
            mem_wr_misaligned <= 1'b0;
        end else begin
            mem_wr_valid      <= accept && aligned;
            mem_wr_misaligned <= accept && !aligned;
        end
    end

    // held until the next aligned store
    always_ff @(posedge clk) begin
        if (accept && aligned) begin
            mem_wr_addr <= addr;
            mem_wr_data <= place_u.dword;
            mem_wr_mask <= size_ones << offs;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gpr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpr_file
    import wb_pkg::*;
#(
    parameter int REG_ADDR_W = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // write port, from writeback
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata,

    // read ports
    input  logic [REG_ADDR_W-1:0] base_addr,
    input  logic [REG_ADDR_W-1:0] src_addr,
    input  logic [REG_ADDR_W-1:0] dbg_addr,
    output logic [XLEN-1:0]       base_data,
    output logic [XLEN-1:0]       src_data,
    output logic [XLEN-1:0]       dbg_data
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    // architectural state starts at zero, so every register is cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin  // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // x0 stays zero from reset, no read mux needed
    assign base_data = regs[base_addr];
    assign src_data  = regs[src_addr];
    assign dbg_data  = regs[dbg_addr];

endmodule

`default_nettype wire

// ==== rtl/wb_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_select
    import wb_pkg::*;
#(
    parameter int REG_ADDR_W = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // writeback strobe and its payload
    input  logic                  wb_valid,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic                  wb_from_mem,
    input  logic [XLEN-1:0]       ex_result,
    input  logic [XLEN-1:0]       mem_result,
    input  ext_mode_e             ext_mode,
    input  logic [XLEN-1:0]       wb_pc,
    input  logic                  ebreak,

    // register file write request
    output logic                  rf_we,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output logic [XLEN-1:0]       rf_wdata,

    output logic                  retire_valid,
    output logic [XLEN-1:0]       retire_pc,
    output logic                  halted
);

    lane_word_u res_u;   // selected result, viewed by lane
    logic       accept;  // instruction actually takes effect

    assign accept = wb_valid && !halted;

    always_comb begin
        res_u = wb_from_mem ? mem_result : ex_result;

        case (ext_mode)
            EXT_SWORD:
                rf_wdata = {{(XLEN-32){res_u.words[0][31]}}, res_u.words[0]};
            EXT_ZWORD:
                rf_wdata = {{(XLEN-32){1'b0}}, res_u.words[0]};
            EXT_SHALF:
                rf_wdata = {{(XLEN-16){res_u.halves[0][15]}}, res_u.halves[0]};
            EXT_ZHALF:
                rf_wdata = {{(XLEN-16){1'b0}}, res_u.halves[0]};
            EXT_SBYTE:
                rf_wdata = {{(XLEN-8){res_u.bytes[0][7]}}, res_u.bytes[0]};
            EXT_ZBYTE:
                rf_wdata = {{(XLEN-8){1'b0}}, res_u.bytes[0]};
            default:
                rf_wdata = res_u.dword;  // EXT_DWORD and unused codes
        endcase
    end

    // x0 filtering is left to the register file
    assign rf_we    = accept;
    assign rf_waddr = wb_rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            retire_valid <= accept;
            if (accept && ebreak) begin
                halted <= 1'b1;  // sticky until reset
            end
        end
    end

    // pc only matters while retire_valid is high
    always_ff @(posedge clk) begin
        if (accept) begin
            retire_pc <= wb_pc;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    localparam int XLEN = 64;

    // destination extension applied at writeback
    typedef enum logic [2:0] {
        EXT_DWORD = 3'd0,  // full 64 bits
        EXT_SWORD = 3'd1,  // lw, addw and friends
        EXT_ZWORD = 3'd2,  // lwu
        EXT_SHALF = 3'd3,  // lh
        EXT_ZHALF = 3'd4,  // lhu
        EXT_SBYTE = 3'd5,  // lb
        EXT_ZBYTE = 3'd6   // lbu
    } ext_mode_e;

    // store width, log2 of the byte count
    typedef enum logic [1:0] {
        ST_BYTE  = 2'd0,
        ST_HALF  = 2'd1,
        ST_WORD  = 2'd2,
        ST_DWORD = 2'd3
    } st_size_e;

    // one data word seen as lanes of different widths
    // index 0 is always the least significant lane
    typedef union packed {
        logic [XLEN-1:0]               dword;
        logic [XLEN/32-1:0][31:0]      words;
        logic [XLEN/16-1:0][15:0]      halves;
        logic [XLEN/8-1:0][7:0]        bytes;
    } lane_word_u;

endpackage

`default_nettype wire
